//--- list.f
+incdir+verilog
verilog/stepper_pkg.sv
verilog/command_parser.sv
verilog/config_registers.sv
verilog/move_buffer.sv
verilog/reply_builder.sv
verilog/stepper_command_top.sv
bench/stepper_command_tb.sv

//--- bench/stepper_command_tb.sv
`timescale 1ns/1ns
`include "stepper_macros.svh"

module stepper_command_tb;

  localparam int clock_period = 100;
  localparam int reset_cycles = 10;
  // Whole sequence including reset runs under 50 cycles
  localparam int watchdog_cycles = 400;

  // DUT inputs
  logic                       word_received;
  logic                       reset;
  logic [63:0]                word_data_received;
  logic [63:0]                encoder_count;
  logic [`MOVE_BUFFER_BITS:0] moveind;
  logic [`MOVE_BUFFER_SIZE:0] stepfinished;

  // DUT outputs
  logic [63:0]                word_send_data;
  logic [`MOVE_BUFFER_SIZE:0] stepready;
  logic                       buffer_dtr;
  logic                       dir;
  logic                       enable;
  logic [63:0]                move_duration;
  logic signed [63:0]         increment;
  logic signed [63:0]         incrementincrement;
  logic [7:0]                 clock_divisor;
  logic [2:0]                 microsteps;
  logic [7:0]                 current;
  logic [9:0]                 config_offtime;
  logic [7:0]                 config_blanktime;
  logic [9:0]                 config_fastdecay_threshold;
  logic [7:0]                 config_minimum_on_time;
  logic [10:0]                config_current_threshold;
  logic [7:0]                 config_chargepump_period;
  logic                       config_invert_highside;
  logic                       config_invert_lowside;

  int     errors;
  integer seed;

  // Expected configuration
  logic        exp_enable;
  logic [7:0]  exp_clock_divisor;
  logic [2:0]  exp_microsteps;
  logic [7:0]  exp_current;
  logic [9:0]  exp_offtime;
  logic [7:0]  exp_blanktime;
  logic [9:0]  exp_fastdecay;
  logic [7:0]  exp_min_on_time;
  logic [10:0] exp_current_threshold;
  logic [7:0]  exp_chargepump;
  logic        exp_invert_high;
  logic        exp_invert_low;

  // Step-timer side model of the ring buffer
  logic [`MOVE_BUFFER_SIZE:0] exp_ready;
  logic [`MOVE_BUFFER_SIZE:0] exp_dir;
  logic [63:0]                exp_duration [0:`MOVE_BUFFER_SIZE];
  logic [63:0]                exp_increment [0:`MOVE_BUFFER_SIZE];
  logic [63:0]                exp_incrincr [0:`MOVE_BUFFER_SIZE];
  int                         exp_write_index;

  stepper_command_top dut0 (
    .word_received              (word_received),
    .reset                      (reset),
    .word_data_received         (word_data_received),
    .encoder_count              (encoder_count),
    .moveind                    (moveind),
    .stepfinished               (stepfinished),
    .word_send_data             (word_send_data),
    .stepready                  (stepready),
    .buffer_dtr                 (buffer_dtr),
    .dir                        (dir),
    .enable                     (enable),
    .move_duration              (move_duration),
    .increment                  (increment),
    .incrementincrement         (incrementincrement),
    .clock_divisor              (clock_divisor),
    .microsteps                 (microsteps),
    .current                    (current),
    .config_offtime             (config_offtime),
    .config_blanktime           (config_blanktime),
    .config_fastdecay_threshold (config_fastdecay_threshold),
    .config_minimum_on_time     (config_minimum_on_time),
    .config_current_threshold   (config_current_threshold),
    .config_chargepump_period   (config_chargepump_period),
    .config_invert_highside     (config_invert_highside),
    .config_invert_lowside      (config_invert_lowside)
  );

  // Word strobe with one rising edge per word
  initial begin
    word_received = 1'b0;
    forever begin
      #(clock_period / 2) word_received = ~word_received;
    end
  end

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Timeout: test sequence did not finish within %0d cycles", watchdog_cycles);
    $display("Errors: %0d", errors);
    $display("Verification failed");
    $finish;
  end

  task automatic compare_value(input string test, input string name,
                               input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("Mismatch %s %s: expected %h, actual %h", test, name, expected, actual);
    end
  endtask

  // Drive on the falling edge and sample just after the rising edge
  task automatic send_word(input logic [63:0] word, input logic [63:0] enc);
    @(negedge word_received);
    word_data_received = word;
    encoder_count      = enc;
    @(posedge word_received);
    #1;
  endtask

  // Room while any slot has ready equal to finished
  function automatic logic expected_dtr();
    logic room;
    room = 1'b0;
    for (int i = 0; i <= `MOVE_BUFFER_SIZE; i++) begin
      if (exp_ready[i] == stepfinished[i]) begin
        room = 1'b1;
      end
    end
    return room;
  endfunction

  task automatic check_config(input string test);
    compare_value(test, "enable", exp_enable, enable);
    compare_value(test, "clock_divisor", exp_clock_divisor, clock_divisor);
    compare_value(test, "microsteps", exp_microsteps, microsteps);
    compare_value(test, "current", exp_current, current);
    compare_value(test, "offtime", exp_offtime, config_offtime);
    compare_value(test, "blanktime", exp_blanktime, config_blanktime);
    compare_value(test, "fastdecay", exp_fastdecay, config_fastdecay_threshold);
    compare_value(test, "minimum_on_time", exp_min_on_time, config_minimum_on_time);
    compare_value(test, "current_threshold", exp_current_threshold, config_current_threshold);
    compare_value(test, "chargepump", exp_chargepump, config_chargepump_period);
    compare_value(test, "invert_high", exp_invert_high, config_invert_highside);
    compare_value(test, "invert_low", exp_invert_low, config_invert_lowside);
  endtask

  // Timer model finishes a slot by toggling its bit
  task automatic finish_slot(input int slot);
    @(negedge word_received);
    stepfinished[slot] = ~stepfinished[slot];
    #1;
  endtask

  // Timer model selects a slot and reads back its move
  task automatic check_slot(input string test, input int slot);
    @(negedge word_received);
    moveind = slot;
    #1;
    compare_value(test, "move_duration", exp_duration[slot], move_duration);
    compare_value(test, "increment", exp_increment[slot], increment);
    compare_value(test, "incrementincrement", exp_incrincr[slot], incrementincrement);
    compare_value(test, "dir", exp_dir[slot], dir);
  endtask

  // Header plus three data words and an idle word
  task automatic send_move(input string test, input logic dir_bit);
    logic [63:0] enc;
    logic [63:0] dur;
    logic [63:0] inc;
    logic [63:0] inc2;
    int          slot;
    slot = exp_write_index;
    enc  = {$random(seed), $random(seed)};
    dur  = {$random(seed), $random(seed)};
    inc  = {$random(seed), $random(seed)};
    inc2 = {$random(seed), $random(seed)};
    send_word({stepper_pkg::op_coordinated_step, 55'd0, dir_bit}, enc);
    compare_value(test, "reply after header", 64'd0, word_send_data);
    // Encoder moves on while the reply keeps the header value
    send_word(dur, ~enc);
    send_word(inc, ~enc);
    compare_value(test, "encoder snapshot", enc, word_send_data);
    send_word(inc2, ~enc);
    compare_value(test, "reply after last word", 64'd0, word_send_data);
    exp_ready[slot]     = ~exp_ready[slot];
    exp_dir[slot]       = dir_bit;
    exp_duration[slot]  = dur;
    exp_increment[slot] = inc;
    exp_incrincr[slot]  = inc2;
    exp_write_index     = (slot == `MOVE_BUFFER_SIZE) ? 0 : slot + 1;
    compare_value(test, "stepready", exp_ready, stepready);
    compare_value(test, "buffer_dtr", expected_dtr(), buffer_dtr);
    send_word(64'd0, ~enc);
  endtask

  task automatic reset_defaults_test();
    compare_value("reset_defaults", "stepready", 0, stepready);
    compare_value("reset_defaults", "buffer_dtr", 1, buffer_dtr);
    compare_value("reset_defaults", "word_send_data", 0, word_send_data);
    check_config("reset_defaults");
  endtask

  task automatic config_commands_test();
    logic [63:0] w;
    w = {stepper_pkg::op_motor_enable, 56'hfedc_ba98_7654_31};
    exp_enable = w[0];
    send_word(w, encoder_count);
    check_config("motor_enable");
    w = {stepper_pkg::op_clk_divisor, 56'h5a5a_5a5a_5a5a_1c};
    exp_clock_divisor = w[7:0];
    send_word(w, encoder_count);
    check_config("clk_divisor");
    w = {stepper_pkg::op_motorconfig, 56'h00_0000_0000_c805};
    exp_current    = w[15:8];
    exp_microsteps = w[2:0];
    send_word(w, encoder_count);
    check_config("motorconfig");
    // Random payload exercises every chopper field at once
    w = {stepper_pkg::op_microstepper_config, 24'(unsigned'($random(seed))),
         32'(unsigned'($random(seed)))};
    exp_offtime           = w[39:30];
    exp_blanktime         = w[29:22];
    exp_fastdecay         = w[21:12];
    exp_min_on_time       = w[47:40];
    exp_current_threshold = w[10:0];
    send_word(w, encoder_count);
    check_config("microstepper_config");
    w = {stepper_pkg::op_chargepump, 56'h3c3c_3c3c_3c3c_4e};
    exp_chargepump = w[7:0];
    send_word(w, encoder_count);
    check_config("chargepump");
    w = {stepper_pkg::op_bridgeinvert, 56'h00_0000_0000_0002};
    exp_invert_high = w[1];
    exp_invert_low  = w[0];
    send_word(w, encoder_count);
    check_config("bridgeinvert");
    // Unlisted header leaves everything alone
    send_word({8'h55, 56'hff_ffff_ffff_ffff}, encoder_count);
    check_config("unknown_header");
    compare_value("unknown_header", "word_send_data", 0, word_send_data);
  endtask

  task automatic version_query_test();
    send_word({stepper_pkg::op_api_version, 56'd0}, encoder_count);
    // Patch in the low byte, minor above it, major above that
    compare_value("version_query", "word_send_data",
                  (64'(`VERSION_MAJOR) << 16) | (64'(`VERSION_MINOR) << 8)
                  | 64'(`VERSION_PATCH), word_send_data);
    // Next word decodes as a fresh header and clears enable
    exp_enable = 1'b0;
    send_word({stepper_pkg::op_motor_enable, 56'd0}, encoder_count);
    check_config("version_followup");
    compare_value("version_followup", "word_send_data", 0, word_send_data);
  endtask

  task automatic coordinated_move_test();
    send_move("coordinated_move", 1'b1);
    check_slot("coordinated_move", 0);
  endtask

  task automatic flow_control_test();
    // Second move fills slot 1 and leaves both slots pending
    send_move("flow_control", 1'b1);
    compare_value("flow_control", "buffer_dtr full", 0, buffer_dtr);
    finish_slot(0);
    compare_value("flow_control", "buffer_dtr freed", 1, buffer_dtr);
    // Third move wraps into slot 0 with the opposite direction
    send_move("flow_control", 1'b0);
    compare_value("flow_control", "stepready wrapped", 2'b10, stepready);
    compare_value("flow_control", "buffer_dtr refilled", 0, buffer_dtr);
    check_slot("flow_control", 0);
    check_slot("flow_control", 1);
  endtask

  initial begin
    errors             = 0;
    seed               = 32'h459735c0;
    reset              = 1'b1;
    word_data_received = 64'd0;
    encoder_count      = 64'd0;
    moveind            = '0;
    stepfinished       = '0;
    // Reference defaults
    exp_enable            = 1'b0;
    exp_clock_divisor     = 8'd40;
    exp_microsteps        = 3'd2;
    exp_current           = 8'd140;
    exp_offtime           = 10'd810;
    exp_blanktime         = 8'd27;
    exp_fastdecay         = 10'd706;
    exp_min_on_time       = 8'd54;
    exp_current_threshold = 11'd1024;
    exp_chargepump        = 8'd91;
    exp_invert_high       = 1'b0;
    exp_invert_low        = 1'b0;
    exp_ready             = '0;
    exp_dir               = '0;
    exp_write_index       = 0;
    repeat (reset_cycles) @(posedge word_received);
    @(negedge word_received);
    reset = 1'b0;
    reset_defaults_test();
    config_commands_test();
    version_query_test();
    coordinated_move_test();
    flow_control_test();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog/stepper_command_top.sv
`timescale 1ns/1ns
`include "stepper_macros.svh"

module stepper_command_top (
  input  logic                       word_received,
  input  logic                       reset,
  input  logic [63:0]                word_data_received,
  input  logic [63:0]                encoder_count,
  input  logic [`MOVE_BUFFER_BITS:0] moveind,
  input  logic [`MOVE_BUFFER_SIZE:0] stepfinished,
  output logic [63:0]                word_send_data,
  output logic [`MOVE_BUFFER_SIZE:0] stepready,
  output logic                       buffer_dtr,
  output logic                       dir,
  output logic                       enable,
  output logic [63:0]                move_duration,
  output logic signed [63:0]         increment,
  output logic signed [63:0]         incrementincrement,
  output logic [7:0]                 clock_divisor,
  output logic [2:0]                 microsteps,
  output logic [7:0]                 current,
  output logic [9:0]                 config_offtime,
  output logic [7:0]                 config_blanktime,
  output logic [9:0]                 config_fastdecay_threshold,
  output logic [7:0]                 config_minimum_on_time,
  output logic [10:0]                config_current_threshold,
  output logic [7:0]                 config_chargepump_period,
  output logic                       config_invert_highside,
  output logic                       config_invert_lowside
);

  // Decoded header and word role
  stepper_pkg::opcode_t     opcode;
  stepper_pkg::move_phase_t move_phase;
  logic                     move_start;

  command_parser parser0 (
    .word_received      (word_received),
    .reset              (reset),
    .word_data_received (word_data_received),
    .opcode             (opcode),
    .move_phase         (move_phase),
    .move_start         (move_start)
  );

  config_registers config0 (
    .word_received              (word_received),
    .reset                      (reset),
    .opcode                     (opcode),
    .word_data_received         (word_data_received),
    .enable                     (enable),
    .clock_divisor              (clock_divisor),
    .microsteps                 (microsteps),
    .current                    (current),
    .config_offtime             (config_offtime),
    .config_blanktime           (config_blanktime),
    .config_fastdecay_threshold (config_fastdecay_threshold),
    .config_minimum_on_time     (config_minimum_on_time),
    .config_current_threshold   (config_current_threshold),
    .config_chargepump_period   (config_chargepump_period),
    .config_invert_highside     (config_invert_highside),
    .config_invert_lowside      (config_invert_lowside)
  );

  // Ring buffer shared with the step timer
  move_buffer buffer0 (
    .word_received      (word_received),
    .reset              (reset),
    .move_phase         (move_phase),
    .move_start         (move_start),
    .word_data_received (word_data_received),
    .moveind            (moveind),
    .stepfinished       (stepfinished),
    .stepready          (stepready),
    .buffer_dtr         (buffer_dtr),
    .dir                (dir),
    .move_duration      (move_duration),
    .increment          (increment),
    .incrementincrement (incrementincrement)
  );

  reply_builder reply0 (
    .word_received  (word_received),
    .reset          (reset),
    .opcode         (opcode),
    .move_phase     (move_phase),
    .encoder_count  (encoder_count),
    .word_send_data (word_send_data)
  );

endmodule

//--- verilog/reply_builder.sv
`timescale 1ns/1ns
`include "stepper_macros.svh"

module reply_builder (
  input  logic                     word_received,
  input  logic                     reset,
  input  stepper_pkg::opcode_t     opcode,
  input  stepper_pkg::move_phase_t move_phase,
  input  logic [63:0]              encoder_count,
  output logic [63:0]              word_send_data
);

  // Encoder position captured with the move header
  logic signed [63:0] encoder_store;

  always_ff @(posedge word_received) begin
    if (opcode == stepper_pkg::op_coordinated_step) begin
      encoder_store <= $signed(encoder_count);
    end
  end

  // Reply shifted out during the next transfer
  always_ff @(posedge word_received) begin
    if (reset) begin
      word_send_data <= '0;
    end else if (opcode == stepper_pkg::op_api_version) begin
      // Major, minor, patch from high byte down
      word_send_data <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
    end else if (move_phase == stepper_pkg::phase_increment) begin
      // Position at the start of this move
      word_send_data <= encoder_store;
    end else begin
      word_send_data <= '0;
    end
  end

endmodule

//--- verilog/move_buffer.sv
`timescale 1ns/1ns
`include "stepper_macros.svh"

module move_buffer (
  input  logic                     word_received,
  input  logic                     reset,
  input  stepper_pkg::move_phase_t   move_phase,
  input  logic                     move_start,
  input  logic [63:0]              word_data_received,
  input  logic [`MOVE_BUFFER_BITS:0] moveind,
  input  logic [`MOVE_BUFFER_SIZE:0] stepfinished,
  output logic [`MOVE_BUFFER_SIZE:0] stepready,
  output logic                     buffer_dtr,
  output logic                     dir,
  output logic [63:0]              move_duration,
  output logic signed [63:0]       increment,
  output logic signed [63:0]       incrementincrement
);

  // Slot currently being filled by the host
  logic [`MOVE_BUFFER_BITS:0] write_index;

  // Per-slot direction
  logic [`MOVE_BUFFER_SIZE:0] dir_slot;

  // Move fields
  stepper_pkg::move_word_t duration_mem [`MOVE_BUFFER_SIZE:0];
  stepper_pkg::move_word_t increment_mem [`MOVE_BUFFER_SIZE:0];
  stepper_pkg::move_word_t incrincr_mem [`MOVE_BUFFER_SIZE:0];

  // Slot pending while ready and finished disagree
  logic [`MOVE_BUFFER_SIZE:0] pending;

  assign pending = stepready ^ stepfinished;

  // Room for at least one more move
  assign buffer_dtr = ~(&pending);

  // Read port for the step timer
  assign dir                = dir_slot[moveind];
  assign move_duration      = duration_mem[moveind];
  assign increment          = $signed(increment_mem[moveind]);
  assign incrementincrement = $signed(incrincr_mem[moveind]);

  // Control state, index and handshake bits
  always_ff @(posedge word_received) begin
    if (reset) begin
      write_index <= '0;
      stepready   <= '0;
      dir_slot    <= '0;
    end else begin
      if (move_start) begin
        dir_slot[write_index] <= word_data_received[0];
      end
      // Final word hands the slot to the timer
      if (move_phase == stepper_pkg::phase_incrincr) begin
        stepready[write_index] <= ~stepready[write_index];
        if (write_index == `MOVE_BUFFER_SIZE) begin
          write_index <= '0;
        end else begin
          write_index <= write_index + 1'b1;
        end
      end
    end
  end

  // Move payload, one field per word
  always_ff @(posedge word_received) begin
    case (move_phase)
      stepper_pkg::phase_duration: begin
        duration_mem[write_index] <= word_data_received;
      end
      stepper_pkg::phase_increment: begin
        increment_mem[write_index] <= word_data_received;
      end
      stepper_pkg::phase_incrincr: begin
        incrincr_mem[write_index] <= word_data_received;
      end
      // Header words carry no payload
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/config_registers.sv
`timescale 1ns/1ns

module config_registers (
  input  logic                 word_received,
  input  logic                 reset,
  input  stepper_pkg::opcode_t opcode,
  input  logic [63:0]          word_data_received,
  output logic                 enable,
  output logic [7:0]           clock_divisor,
  output logic [2:0]           microsteps,
  output logic [7:0]           current,
  output logic [9:0]           config_offtime,
  output logic [7:0]           config_blanktime,
  output logic [9:0]           config_fastdecay_threshold,
  output logic [7:0]           config_minimum_on_time,
  output logic [10:0]          config_current_threshold,
  output logic [7:0]           config_chargepump_period,
  output logic                 config_invert_highside,
  output logic                 config_invert_lowside
);

  always_ff @(posedge word_received) begin
    if (reset) begin
      // Motor off until the host enables it
      enable                     <= 1'b0;
      // 400 kHz step clock at 16 MHz
      clock_divisor              <= 8'd40;
      microsteps                 <= 3'd2;
      current                    <= 8'd140;
      // Chopper defaults
      config_offtime             <= 10'd810;
      config_blanktime           <= 8'd27;
      config_fastdecay_threshold <= 10'd706;
      config_minimum_on_time     <= 8'd54;
      config_current_threshold   <= 11'd1024;
      config_chargepump_period   <= 8'd91;
      config_invert_highside     <= 1'b0;
      config_invert_lowside      <= 1'b0;
    end else begin
      case (opcode)
        stepper_pkg::op_motor_enable: begin
          enable <= word_data_received[0];
        end
        stepper_pkg::op_clk_divisor: begin
          clock_divisor <= word_data_received[7:0];
        end
        // Current in the second byte, microsteps in the low bits
        stepper_pkg::op_motorconfig: begin
          current    <= word_data_received[15:8];
          microsteps <= word_data_received[2:0];
        end
        // Five chopper fields in one word
        stepper_pkg::op_microstepper_config: begin
          config_offtime             <= word_data_received[39:30];
          config_blanktime           <= word_data_received[29:22];
          config_fastdecay_threshold <= word_data_received[21:12];
          // Own byte, clear of the fast-decay field
          config_minimum_on_time     <= word_data_received[47:40];
          config_current_threshold   <= word_data_received[10:0];
        end
        stepper_pkg::op_chargepump: begin
          config_chargepump_period <= word_data_received[7:0];
        end
        // Bridge polarity
        stepper_pkg::op_bridgeinvert: begin
          config_invert_highside <= word_data_received[1];
          config_invert_lowside  <= word_data_received[0];
        end
        // Moves, version query and unknown headers leave config alone
        default: begin
        end
      endcase
    end
  end

endmodule

//--- verilog/command_parser.sv
`timescale 1ns/1ns

module command_parser (
  input  logic                   word_received,
  input  logic                   reset,
  input  logic [63:0]            word_data_received,
  output stepper_pkg::opcode_t     opcode,
  output stepper_pkg::move_phase_t move_phase,
  output logic                   move_start
);

  // Phase of the next word to arrive
  stepper_pkg::move_phase_t phase_q;
  stepper_pkg::move_phase_t phase_d;

  // Header field decoded regardless of phase
  stepper_pkg::opcode_t header_op;

  // Map raw header byte onto the opcode set
  always_comb begin
    case (word_data_received[63:56])
      stepper_pkg::op_coordinated_step,
      stepper_pkg::op_motor_enable,
      stepper_pkg::op_clk_divisor,
      stepper_pkg::op_motorconfig,
      stepper_pkg::op_microstepper_config,
      stepper_pkg::op_chargepump,
      stepper_pkg::op_bridgeinvert,
      stepper_pkg::op_api_version: begin
        header_op = stepper_pkg::opcode_t'(word_data_received[63:56]);
      end
      // Anything unlisted is ignored downstream
      default: begin
        header_op = stepper_pkg::op_none;
      end
    endcase
  end

  // Only header words carry an opcode
  assign opcode = (phase_q == stepper_pkg::phase_header) ? header_op
                                                         : stepper_pkg::op_none;

  // Current word role comes straight from the state
  assign move_phase = phase_q;

  // Header of a move, direction lives in bit 0
  assign move_start = (opcode == stepper_pkg::op_coordinated_step);

  // Sequence the three data words after a move header
  always_comb begin
    case (phase_q)
      stepper_pkg::phase_header: begin
        if (move_start) begin
          phase_d = stepper_pkg::phase_duration;
        end else begin
          // Version query and config commands are one word
          phase_d = stepper_pkg::phase_header;
        end
      end
      stepper_pkg::phase_duration: begin
        phase_d = stepper_pkg::phase_increment;
      end
      stepper_pkg::phase_increment: begin
        phase_d = stepper_pkg::phase_incrincr;
      end
      // Last move word, back to expecting a header
      default: begin
        phase_d = stepper_pkg::phase_header;
      end
    endcase
  end

  // State register
  always_ff @(posedge word_received) begin
    if (reset) begin
      phase_q <= stepper_pkg::phase_header;
    end else begin
      phase_q <= phase_d;
    end
  end

endmodule

//--- verilog/stepper_pkg.sv
package stepper_pkg;

  // Header opcodes, carried in bits 63:56 of a header word
  typedef enum logic [7:0] {
    op_none                = 8'h00,
    // Four-word move, direction in bit 0 of the header
    op_coordinated_step    = 8'h01,
    op_motor_enable        = 8'h0a,
    op_clk_divisor         = 8'h0b,
    // Current and microstep count
    op_motorconfig         = 8'h10,
    // Chopper timing and thresholds
    op_microstepper_config = 8'h16,
    op_chargepump          = 8'h31,
    op_bridgeinvert        = 8'h32,
    // Single word, reply carries the version
    op_api_version         = 8'hfe
  } opcode_t;

  // Role of the word arriving on this edge
  typedef enum logic [1:0] {
    phase_header    = 2'd0,
    phase_duration  = 2'd1,
    phase_increment = 2'd2,
    phase_incrincr  = 2'd3
  } move_phase_t;

  // One field of a buffered move
  typedef logic [63:0] move_word_t;

endpackage

//--- verilog/stepper_macros.svh
`ifndef STEPPER_MACROS_SVH
`define STEPPER_MACROS_SVH

// Move ring buffer geometry

// Index width minus one
`define MOVE_BUFFER_BITS 0

// Slot count minus one, two slots
`define MOVE_BUFFER_SIZE 1

// API version reported on the version query
// Major number, reply bits 23:16
`define VERSION_MAJOR 8'd0

// Minor number, reply bits 15:8
`define VERSION_MINOR 8'd3

// Patch number, reply bits 7:0
`define VERSION_PATCH 8'd1

`endif
